/* rv32e_pkg.sv */
// rv32e execute package: opcodes, alu operations, instruction views and pipeline structs
`default_nettype none

package rv32e_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    // machine register 16 (mstatus) comes out of reset with mpp = 11
    localparam logic [xlen-1:0] mstatus_reset = 32'h0000_1800;

    typedef enum logic [6:0] {
        op_reg = 7'b0110011,
        op_imm = 7'b0010011,
        op_lui = 7'b0110111
    } opcode_e;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_and    = 4'd2,
        alu_or     = 4'd3,
        alu_xor    = 4'd4,
        alu_slt    = 4'd5,
        alu_sltu   = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_pass_b = 4'd9
    } alu_op_e;

    // funct3 codes shared by the reg and imm groups
    localparam logic [2:0] f3_add  = 3'b000;   // add, sub, addi
    localparam logic [2:0] f3_sll  = 3'b001;
    localparam logic [2:0] f3_slt  = 3'b010;
    localparam logic [2:0] f3_sltu = 3'b011;
    localparam logic [2:0] f3_xor  = 3'b100;
    localparam logic [2:0] f3_srl  = 3'b101;
    localparam logic [2:0] f3_or   = 3'b110;
    localparam logic [2:0] f3_and  = 3'b111;

    localparam logic [6:0] f7_base = 7'b0000000;
    localparam logic [6:0] f7_alt  = 7'b0100000;   // sub

    typedef struct packed {
        logic [6:0]           funct7;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        opcode_e              opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]          imm12;
        logic [reg_idx_w-1:0] rs1;
        logic [2:0]           funct3;
        logic [reg_idx_w-1:0] rd;
        opcode_e              opcode;
    } i_fmt_t;

    // one instruction word, two ways of reading it
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } inst_word_u;

    typedef struct packed {
        logic [reg_idx_w-1:0] rs1;
        logic [reg_idx_w-1:0] rs2;
        logic [reg_idx_w-1:0] rd;
        alu_op_e              alu_op;
        logic                 use_imm;   // b operand from immediate
        logic                 reg_wr;
        logic                 illegal;
    } ctrl_t;

    typedef struct packed {
        logic                 valid;
        logic [reg_idx_w-1:0] rd;
        logic [xlen-1:0]      data;
        logic                 reg_error;   // write index out of range
        logic                 illegal;
    } wb_t;

endpackage

`default_nettype wire

/* rv32e_decoder.sv */
// instruction decoder: splits the word into register fields, alu operation and immediate
`default_nettype none

module rv32e_decoder (
    input  var rv32e_pkg::inst_word_u    inst,
    input  wire logic                    inst_valid,
    output rv32e_pkg::ctrl_t             ctrl,
    output logic [rv32e_pkg::xlen-1:0]   imm
);

    logic illegal;
    logic [9:0] funct;   // funct7 and funct3 of the r view

    assign funct = {inst.r_fmt.funct7, inst.r_fmt.funct3};

    always_comb begin
        illegal      = 1'b0;
        imm          = '0;
        ctrl         = '0;
        ctrl.rs1     = inst.r_fmt.rs1;
        ctrl.rs2     = inst.r_fmt.rs2;
        ctrl.rd      = inst.r_fmt.rd;
        ctrl.alu_op  = rv32e_pkg::alu_add;
        ctrl.use_imm = 1'b0;

        case (inst.r_fmt.opcode)
            rv32e_pkg::op_reg: begin
                case (funct)
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_add}:  ctrl.alu_op = rv32e_pkg::alu_add;
                    {rv32e_pkg::f7_alt,  rv32e_pkg::f3_add}:  ctrl.alu_op = rv32e_pkg::alu_sub;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_and}:  ctrl.alu_op = rv32e_pkg::alu_and;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_or}:   ctrl.alu_op = rv32e_pkg::alu_or;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_xor}:  ctrl.alu_op = rv32e_pkg::alu_xor;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_slt}:  ctrl.alu_op = rv32e_pkg::alu_slt;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_sltu}: ctrl.alu_op = rv32e_pkg::alu_sltu;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_sll}:  ctrl.alu_op = rv32e_pkg::alu_sll;
                    {rv32e_pkg::f7_base, rv32e_pkg::f3_srl}:  ctrl.alu_op = rv32e_pkg::alu_srl;
                    default: illegal = 1'b1;   // sra and friends not kept
                endcase
            end

            rv32e_pkg::op_imm: begin
                // i view: sign extended 12 bit immediate
                ctrl.use_imm = 1'b1;
                imm = {{20{inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};
                case (inst.i_fmt.funct3)
                    rv32e_pkg::f3_add: ctrl.alu_op = rv32e_pkg::alu_add;
                    rv32e_pkg::f3_and: ctrl.alu_op = rv32e_pkg::alu_and;
                    rv32e_pkg::f3_or:  ctrl.alu_op = rv32e_pkg::alu_or;
                    rv32e_pkg::f3_xor: ctrl.alu_op = rv32e_pkg::alu_xor;
                    rv32e_pkg::f3_slt: ctrl.alu_op = rv32e_pkg::alu_slt;
                    default: illegal = 1'b1;   // shift and sltiu forms
                endcase
            end

            rv32e_pkg::op_lui: begin
                // u immediate rebuilt from the upper part of the i view
                ctrl.use_imm = 1'b1;
                ctrl.alu_op  = rv32e_pkg::alu_pass_b;
                imm = {inst.i_fmt.imm12, inst.i_fmt.rs1, inst.i_fmt.funct3, 12'h000};
            end

            default: illegal = 1'b1;
        endcase

        ctrl.illegal = illegal;
        // x0 target needs no write at all
        ctrl.reg_wr  = inst_valid && !illegal && (ctrl.rd != '0);
    end

endmodule

`default_nettype wire

/* rv32e_reg_file.sv */
// register file: general registers plus four machine registers, two reads and one write
`default_nettype none

module rv32e_reg_file #(
    parameter int gpr_count = 16,
    parameter int csr_count = 4
) (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic [rv32e_pkg::reg_idx_w-1:0]  rs1,
    input  wire logic [rv32e_pkg::reg_idx_w-1:0]  rs2,
    input  wire logic [rv32e_pkg::reg_idx_w-1:0]  rd,
    input  wire logic                             reg_wr,
    input  wire logic [rv32e_pkg::xlen-1:0]       wr_data,
    output logic [rv32e_pkg::xlen-1:0]            rd_data_a,
    output logic [rv32e_pkg::xlen-1:0]            rd_data_b,
    output logic                                  wr_range_error
);

    localparam int total_count = gpr_count + csr_count;
    localparam int gpr_idx_w   = $clog2(gpr_count);
    localparam int csr_idx_w   = $clog2(csr_count);

    // csr[0] mstatus, csr[1] mtvec, csr[2] mepc, csr[3] mcause
    logic [rv32e_pkg::xlen-1:0] gpr [gpr_count];
    logic [rv32e_pkg::xlen-1:0] csr [csr_count];

    function automatic logic [rv32e_pkg::xlen-1:0] read_reg(
        input logic [rv32e_pkg::reg_idx_w-1:0] idx
    );
        logic [rv32e_pkg::xlen-1:0] val;
        val = '0;
        if (int'(idx) < gpr_count) begin
            val = gpr[gpr_idx_w'(idx)];   // x0 keeps its reset zero
        end else if (int'(idx) < total_count) begin
            val = csr[csr_idx_w'(int'(idx) - gpr_count)];
        end
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < gpr_count; i++) begin
                gpr[i] <= '0;
            end
            for (int i = 1; i < csr_count; i++) begin
                csr[i] <= '0;
            end
            csr[0] <= rv32e_pkg::mstatus_reset;
        end else if (reg_wr && rd != '0) begin   // x0 ignores writes
            if (int'(rd) < gpr_count) begin
                gpr[gpr_idx_w'(rd)] <= wr_data;
            end else if (int'(rd) < total_count) begin
                csr[csr_idx_w'(int'(rd) - gpr_count)] <= wr_data;
            end
            // anything above the machine registers is dropped here
        end
    end

    always_comb begin
        rd_data_a = read_reg(rs1);
        rd_data_b = read_reg(rs2);
    end

    // flagged, not trapped
    assign wr_range_error = reg_wr && (int'(rd) >= total_count);

endmodule

`default_nettype wire

/* rv32e_alu.sv */
// alu: add/sub, logic, signed and unsigned compare, logical shifts, operand pass
`default_nettype none

module rv32e_alu (
    input  var rv32e_pkg::alu_op_e             alu_op,
    input  wire logic [rv32e_pkg::xlen-1:0]    a,
    input  wire logic [rv32e_pkg::xlen-1:0]    b,
    output logic [rv32e_pkg::xlen-1:0]         result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];   // only low five bits count
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            rv32e_pkg::alu_add: begin
                result = a + b;
            end
            rv32e_pkg::alu_sub: begin
                result = a - b;
            end
            rv32e_pkg::alu_and: begin
                result = a & b;
            end
            rv32e_pkg::alu_or: begin
                result = a | b;
            end
            rv32e_pkg::alu_xor: begin
                result = a ^ b;
            end
            rv32e_pkg::alu_slt: begin
                result = {31'b0, lt_signed};
            end
            rv32e_pkg::alu_sltu: begin
                result = {31'b0, lt_unsigned};
            end
            rv32e_pkg::alu_sll: begin
                result = a << shamt;
            end
            rv32e_pkg::alu_srl: begin
                result = a >> shamt;   // zero fill
            end
            rv32e_pkg::alu_pass_b: begin
                result = b;   // lui
            end
            default: begin
                result = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* rv32e_exec_top.sv */
// single-cycle rv32e execute top: decode, register read, alu, writeback and status register
`default_nettype none

module rv32e_exec_top #(
    parameter int gpr_count = 16,
    parameter int csr_count = 4
) (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  var rv32e_pkg::inst_word_u     inst,
    input  wire logic                     inst_valid,
    output rv32e_pkg::wb_t                wb
);

    rv32e_pkg::ctrl_t           ctrl;
    logic [rv32e_pkg::xlen-1:0] imm;
    logic [rv32e_pkg::xlen-1:0] rd_data_a;
    logic [rv32e_pkg::xlen-1:0] rd_data_b;
    logic [rv32e_pkg::xlen-1:0] alu_b;
    logic [rv32e_pkg::xlen-1:0] result;
    logic                       wr_range_error;

    rv32e_decoder i_decoder (
        .inst       (inst),
        .inst_valid (inst_valid),
        .ctrl       (ctrl),
        .imm        (imm)
    );

    rv32e_reg_file #(
        .gpr_count (gpr_count),
        .csr_count (csr_count)
    ) i_reg_file (
        .clk            (clk),
        .rst            (rst),
        .rs1            (ctrl.rs1),
        .rs2            (ctrl.rs2),
        .rd             (ctrl.rd),
        .reg_wr         (ctrl.reg_wr),
        .wr_data        (result),
        .rd_data_a      (rd_data_a),
        .rd_data_b      (rd_data_b),
        .wr_range_error (wr_range_error)
    );

    assign alu_b = ctrl.use_imm ? imm : rd_data_b;

    rv32e_alu i_alu (
        .alu_op (ctrl.alu_op),
        .a      (rd_data_a),
        .b      (alu_b),
        .result (result)
    );

    // status shows up one cycle after the strobe, for one cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wb <= '0;
        end else begin
            wb.valid     <= inst_valid;
            wb.reg_error <= wr_range_error;   // reg_wr already implies a strobe
            wb.illegal   <= inst_valid && ctrl.illegal;
            if (inst_valid) begin
                wb.rd   <= ctrl.rd;
                wb.data <= ctrl.illegal ? '0 : result;
            end
        end
    end

endmodule

`default_nettype wire

/* rv32e_reg_file_chk.sv */
// register file checker: zero register, range flag and register hold properties
`default_nettype none

module rv32e_reg_file_chk #(
    parameter int gpr_count = 16,
    parameter int csr_count = 4
) (
    input wire logic        clk,
    input wire logic        rst,
    input wire logic [4:0]  rs1,
    input wire logic [4:0]  rs2,
    input wire logic        reg_wr,
    input wire logic        wr_range_error,
    input wire logic [31:0] rd_data_a,
    input wire logic [31:0] rd_data_b,
    input wire logic [31:0] gpr [gpr_count],
    input wire logic [31:0] csr [csr_count]
);

    a_zero_a: assert property (@(posedge clk) disable iff (rst)
        rs1 == 5'd0 |-> rd_data_a == 32'h0) else $error("x0 on read port a is not zero");
    a_zero_b: assert property (@(posedge clk) disable iff (rst)
        rs2 == 5'd0 |-> rd_data_b == 32'h0) else $error("x0 on read port b is not zero");

    a_range_needs_wr: assert property (@(posedge clk) disable iff (rst)
        wr_range_error |-> reg_wr) else $error("range error raised without a write");

    // nothing may move without a write, and a refused write moves nothing either
    for (genvar i = 0; i < gpr_count; i++) begin : g_gpr_hold
        a_hold: assert property (@(posedge clk)
            !rst && (!reg_wr || wr_range_error) |=> $stable(gpr[i]))
            else $error("general register %0d changed without an accepted write", i);
    end
    for (genvar i = 0; i < csr_count; i++) begin : g_csr_hold
        a_hold: assert property (@(posedge clk)
            !rst && (!reg_wr || wr_range_error) |=> $stable(csr[i]))
            else $error("machine register %0d changed without an accepted write", i);
    end

endmodule

`default_nettype wire

/* rv32e_exec_scoreboard.sv */
// scoreboard: models the register file, predicts each writeback and compares it with the DUT
`default_nettype none

module rv32e_exec_scoreboard (
    input  wire logic                 clk,
    input  wire logic                 rst,
    input  var rv32e_pkg::inst_word_u inst,
    input  wire logic                 inst_valid,
    input  var rv32e_pkg::wb_t        wb,
    output logic                      busy,
    output int                        err_count,
    output int                        check_count
);

    logic [31:0]    model [20];   // x0..x15, mstatus, mtvec, mepc, mcause
    rv32e_pkg::wb_t exp_q [$];

    function automatic logic [31:0] read_model(input logic [4:0] idx);
        if (idx == 5'd0 || idx >= 5'd20) begin
            return 32'h0;   // x0 and unmapped indices
        end
        return model[idx];
    endfunction

    // expected writeback for one instruction word, from the current model state
    function automatic rv32e_pkg::wb_t predict(input logic [31:0] w);
        rv32e_pkg::wb_t e;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    imm;
        logic [31:0]    res;
        logic           bad;
        a   = read_model(w[19:15]);
        b   = read_model(w[24:20]);
        imm = {{20{w[31]}}, w[31:20]};
        res = 32'h0;
        bad = 1'b0;
        case (w[6:0])
            7'b0110011: begin
                case ({w[31:25], w[14:12]})
                    10'b0000000_000: res = a + b;
                    10'b0100000_000: res = a - b;
                    10'b0000000_111: res = a & b;
                    10'b0000000_110: res = a | b;
                    10'b0000000_100: res = a ^ b;
                    10'b0000000_010: res = {31'h0, $signed(a) < $signed(b)};
                    10'b0000000_011: res = {31'h0, a < b};
                    10'b0000000_001: res = a << b[4:0];
                    10'b0000000_101: res = a >> b[4:0];
                    default:         bad = 1'b1;
                endcase
            end
            7'b0010011: begin
                case (w[14:12])
                    3'b000:  res = a + imm;
                    3'b111:  res = a & imm;
                    3'b110:  res = a | imm;
                    3'b100:  res = a ^ imm;
                    3'b010:  res = {31'h0, $signed(a) < $signed(imm)};
                    default: bad = 1'b1;   // shifts and sltiu are not kept
                endcase
            end
            7'b0110111: res = {w[31:12], 12'h0};
            default:    bad = 1'b1;
        endcase
        e.valid     = 1'b1;
        e.rd        = w[11:7];
        e.data      = bad ? 32'h0 : res;
        e.reg_error = !bad && (w[11:7] >= 5'd20);
        e.illegal   = bad;
        return e;
    endfunction

    always @(posedge clk) begin
        rv32e_pkg::wb_t expected;
        if (rst) begin
            for (int i = 0; i < 20; i++) begin
                model[i] = 32'h0;
            end
            model[16] = 32'h0000_1800;   // mstatus, mpp = 11
            exp_q.delete();
        end else begin
            if (exp_q.size() != 0) begin
                expected = exp_q.pop_front();
                check_count++;
                if (wb !== expected) begin
                    err_count++;
                    $display("** Error at %0t: wb v%b rd %0d data %h err %b ill %b, %s %0d %h %b %b",
                        $time, wb.valid, wb.rd, wb.data, wb.reg_error, wb.illegal, "expected",
                        expected.rd, expected.data, expected.reg_error, expected.illegal);
                end
            end else if (wb.valid || wb.reg_error || wb.illegal) begin
                err_count++;
                $display("** Error at %0t: wb status active without a strobe", $time);
            end
            if (inst_valid) begin
                expected = predict(inst);
                exp_q.push_back(expected);
                if (!expected.illegal && !expected.reg_error && expected.rd != 5'd0) begin
                    model[expected.rd] = expected.data;
                end
            end
        end
        busy = (exp_q.size() != 0);
    end

endmodule

`default_nettype wire

/* tb_rv32e_exec.sv */
// testbench top: clock, reset, directed and random instruction streams, closing verdict
`default_nettype none

module tb_rv32e_exec;

    logic                  clk;
    logic                  rst;
    rv32e_pkg::inst_word_u inst;
    logic                  inst_valid;
    rv32e_pkg::wb_t        wb;
    logic                  busy;
    int                    err_count;
    int                    check_count;
    int                    test_errs;
    logic                  timed_out;

    rv32e_exec_top #(.gpr_count(16), .csr_count(4)) i_dut (
        .clk(clk), .rst(rst), .inst(inst), .inst_valid(inst_valid), .wb(wb)
    );

    rv32e_exec_scoreboard i_scoreboard (
        .clk(clk), .rst(rst), .inst(inst), .inst_valid(inst_valid), .wb(wb),
        .busy(busy), .err_count(err_count), .check_count(check_count)
    );

    bind rv32e_reg_file rv32e_reg_file_chk #(
        .gpr_count(gpr_count), .csr_count(csr_count)
    ) i_reg_file_chk (
        .clk(clk), .rst(rst), .rs1(rs1), .rs2(rs2), .reg_wr(reg_wr),
        .wr_range_error(wr_range_error), .rd_data_a(rd_data_a), .rd_data_b(rd_data_b),
        .gpr(gpr), .csr(csr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
        input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
        input logic [2:0] f3, input logic [4:0] rd);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [4:0] pick_reg(input logic [3:0] v);
        return (v == 4'd0) ? 5'd1 : {1'b0, v};   // x1..x15 only
    endfunction

    task automatic issue(input logic [31:0] w);
        @(negedge clk);
        inst       = w;
        inst_valid = 1'b1;
    endtask

    task automatic pause();
        @(negedge clk);
        inst_valid = 1'b0;
    endtask

    task automatic close_test(input string name);
        int waited;
        pause();
        waited = 0;
        while (busy && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (busy) begin
            timed_out = 1'b1;
            $display("test %s: writeback for the last instruction never arrived", name);
        end
        $display("test %s done, %0d errors", name, err_count - test_errs);
        test_errs = err_count;
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] s;
        logic [2:0]  f3;
        void'($urandom(21920));
        rst        = 1'b1;
        inst       = '0;
        inst_valid = 1'b0;
        timed_out  = 1'b0;
        test_errs  = 0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int i = 16; i < 20; i++) begin
            issue(i_type(12'h0, 5'(i), 3'b000, 5'(i - 15)));   // addi xN, x16+, 0
        end
        close_test("reset_values");

        for (int i = 1; i < 16; i++) begin
            issue(u_type(20'($urandom), 5'(i)));
            issue(i_type(12'($urandom), 5'(i), 3'b000, 5'(i)));
        end
        for (int n = 0; n < 200; n++) begin
            r = $urandom;
            s = $urandom;
            f3 = r[7:5];
            if (f3[0] && f3 != 3'b111) begin
                f3[0] = 1'b0;   // stay on kept i-type ops
            end
            if (r[0]) begin
                issue(r_type((r[3:1] == 3'b000 && r[4]) ? 7'h20 : 7'h00, pick_reg(s[11:8]),
                    pick_reg(s[7:4]), r[3:1], pick_reg(s[3:0])));
            end else begin
                issue(i_type(r[31:20], pick_reg(s[7:4]), f3, pick_reg(s[3:0])));
            end
            if (r[9:8] == 2'b00) begin
                pause();
            end
        end
        close_test("random_ops");

        issue(i_type(12'h123, 5'd5, 3'b000, 5'd0));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b110, 5'd0));
        issue(u_type(20'hfffff, 5'd0));
        issue(r_type(7'h00, 5'd0, 5'd0, 3'b000, 5'd9));
        issue(i_type(12'h000, 5'd0, 3'b000, 5'd10));
        close_test("zero_reg");

        issue(u_type(20'h12345, 5'd17));
        issue(i_type(12'h7ff, 5'd3, 3'b110, 5'd18));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b100, 5'd19));
        issue(i_type(12'h0a5, 5'd0, 3'b000, 5'd16));
        for (int i = 20; i < 32; i++) begin
            issue(i_type(12'h5a5, 5'd4, 3'b000, 5'(i)));   // refused, flagged
        end
        for (int i = 16; i < 24; i++) begin
            issue(i_type(12'h000, 5'(i), 3'b000, 5'(i - 11)));
        end
        close_test("machine_regs");

        issue(u_type(20'habcde, 5'd7));
        issue(32'h0000_2083);                              // lw, not kept
        issue(r_type(7'h20, 5'd2, 5'd1, 3'b101, 5'd3));   // sra
        issue(i_type(12'h003, 5'd7, 3'b001, 5'd8));       // slli
        issue(32'hffff_ffff);
        for (int i = 1; i < 16; i++) begin
            issue(i_type(12'h000, 5'(i), 3'b000, 5'(i)));
        end
        close_test("lui_illegal");

        // each step reads the rd of the one before
        issue(i_type(12'h001, 5'd0, 3'b000, 5'd1));
        issue(r_type(7'h00, 5'd1, 5'd1, 3'b000, 5'd2));
        issue(r_type(7'h00, 5'd2, 5'd1, 3'b001, 5'd3));
        issue(r_type(7'h20, 5'd2, 5'd3, 3'b000, 5'd4));
        issue(i_type(12'hfff, 5'd4, 3'b000, 5'd5));
        issue(r_type(7'h00, 5'd5, 5'd4, 3'b011, 5'd6));
        issue(r_type(7'h00, 5'd6, 5'd5, 3'b101, 5'd7));
        issue(i_type(12'h800, 5'd7, 3'b010, 5'd8));
        close_test("chained");

        $display("all tests done: %0d checks, %0d errors", check_count, err_count);
        if (timed_out || err_count != 0) begin
            $display("Simulation finished: FAIL");
        end else begin
            $display("Simulation finished: PASS");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
rv32e_pkg.sv
rv32e_decoder.sv
rv32e_reg_file.sv
rv32e_alu.sv
rv32e_exec_top.sv
rv32e_reg_file_chk.sv
rv32e_exec_scoreboard.sv
tb_rv32e_exec.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the rv32e execute testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_rv32e_exec -f flist.f -o tb_rv32e_exec
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_rv32e_exec > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "^Simulation finished: PASS$" "$log"; then
    echo "result: pass"
    exit 0
fi
echo "result: fail, pass message not found in $log"
exit 1
